/* project.f */
hdl/nlop_pkg.sv
hdl/nlop_operand_capture.sv
hdl/nlop_sequencer.sv
hdl/nlop_datapath.sv
hdl/nlop_result_hold.sv
hdl/nlop_top.sv
tb/nlop_assertions.sv
tb/nlop_tb.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build nlop_tb with Verilator, run it, check sim.log for a pass"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module nlop_tb -Mdir obj_dir -o nlop_sim
	./obj_dir/nlop_sim | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* tb/nlop_tb.sv */
`timescale 1ns/1ps

module nlop_tb;

  localparam int NROWS = 12;
  localparam int LIMIT = 200;  // cycles allowed for any wait
  localparam int MODE_HIGH = 0;
  localparam int MODE_RANDOM = 1;
  localparam int MODE_LOW = 2;

  // exp coefficients, z = floor(-qin / 355)
  localparam int QLN2 = -355;
  localparam int QLN2_INV = -184;  // about -2^16 / 355
  localparam int FP_BITS = 16;
  localparam int EXP_QB = 693;
  localparam int EXP_QC = 240000;
  // gelu coefficients
  localparam int GELU_QB = -1770;
  localparam int GELU_QC = 3132900;  // qb squared
  localparam int Q1 = 1024;
  localparam int SHIFT = 10;

  typedef struct {
    nlop_pkg::op_t op;
    int qin, qb, qc, qln2, qln2_inv, fp_bits, q1, shift;
    bit bp;  // random out_ready while this row runs
  } row_t;

  row_t rows[NROWS];

  logic clk, rst, in_valid, in_ready, out_valid;
  logic out_ready = 1'b1;
  nlop_pkg::op_t op;
  nlop_pkg::data_t qin, qb, qc, qln2, qln2_inv, fp_bits, q1, shift, qout;

  nlop_pkg::data_t exp_vals[64];  // expected qout, by request number
  int sent_count = 0;
  int recv_count = 0;
  int ready_mode = MODE_HIGH;
  int errors = 0;
  int checks = 0;
  int timeouts = 0;
  int mon_errors = 0;
  int mon_checks = 0;
  logic [31:0] lfsr = 32'h7ad3cca7;
  logic held = 1'b0;
  nlop_pkg::data_t held_val;

  nlop_top uut (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid), .out_ready_i(out_ready), .op_i(op),
    .qin_i(qin), .qb_i(qb), .qc_i(qc), .qln2_i(qln2), .qln2_inv_i(qln2_inv),
    .fp_bits_i(fp_bits), .q1_i(q1), .shift_i(shift),
    .in_ready_o(in_ready), .out_valid_o(out_valid), .qout_o(qout)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 32'hB4BC_D35C) : (s >> 1);
  endfunction

  function automatic nlop_pkg::wide_t widen(input nlop_pkg::data_t v);
    widen = nlop_pkg::wide_t'($signed(v));
  endfunction

  function automatic logic is_neg(input nlop_pkg::wide_t w);
    is_neg = w[nlop_pkg::WIDE_W-1];
  endfunction

  function automatic nlop_pkg::data_t exp_model(input row_t r);
    nlop_pkg::wide_t z, p, poly;
    z = (widen(r.qin) * widen(r.qln2_inv)) >>> nlop_pkg::shamt_t'(r.fp_bits);
    p = widen(r.qin) - widen(r.qln2) * z;
    poly = (p + widen(r.qb)) * p + widen(r.qc);
    poly = poly >>> nlop_pkg::shamt_t'(z);
    exp_model = poly[nlop_pkg::DATA_W-1:0];
  endfunction

  function automatic nlop_pkg::data_t gelu_model(input row_t r);
    nlop_pkg::wide_t x, b, one, mag, clip, sgn, l, res;
    x = widen(r.qin);
    b = widen(r.qb);
    one = nlop_pkg::wide_t'(1);
    mag = is_neg(x) ? -x : x;
    clip = is_neg(-b - mag) ? -b : mag;  // min(|x|, -b)
    sgn = is_neg(x) ? -one : one;
    l = (((b + b + clip) * clip) + widen(r.qc)) * sgn;
    l = l >>> nlop_pkg::shamt_t'(r.shift);
    res = (l + widen(r.q1)) * x;
    gelu_model = res[nlop_pkg::DATA_W-1:0];
  endfunction

  function automatic nlop_pkg::data_t model(input row_t r);
    model = (r.op == nlop_pkg::OP_EXP) ? exp_model(r) : gelu_model(r);
  endfunction

  task automatic fill_table();
    rows[0]  = '{nlop_pkg::OP_EXP,  -1000, EXP_QB,  EXP_QC,  QLN2, QLN2_INV, FP_BITS, Q1, SHIFT, 1'b0};
    rows[1]  = '{nlop_pkg::OP_EXP,    -50, EXP_QB,  EXP_QC,  QLN2, QLN2_INV, FP_BITS, Q1, SHIFT, 1'b0};
    rows[2]  = '{nlop_pkg::OP_EXP,  -3000, EXP_QB,  EXP_QC,  QLN2, QLN2_INV, FP_BITS, Q1, SHIFT, 1'b0};
    rows[3]  = '{nlop_pkg::OP_EXP,  -7900, EXP_QB,  EXP_QC,  QLN2, QLN2_INV, FP_BITS, Q1, SHIFT, 1'b0};
    rows[4]  = '{nlop_pkg::OP_GELU,   500, GELU_QB, GELU_QC, QLN2, QLN2_INV, FP_BITS, Q1, SHIFT, 1'b0};
    rows[5]  = '{nlop_pkg::OP_GELU,  -800, GELU_QB, GELU_QC, QLN2, QLN2_INV, FP_BITS, Q1, SHIFT, 1'b0};
    rows[6]  = '{nlop_pkg::OP_GELU,  2500, GELU_QB, GELU_QC, QLN2, QLN2_INV, FP_BITS, Q1, SHIFT, 1'b0};
    rows[7]  = '{nlop_pkg::OP_EXP,   -400, EXP_QB,  EXP_QC,  QLN2, QLN2_INV, FP_BITS, Q1, SHIFT, 1'b1};
    rows[8]  = '{nlop_pkg::OP_GELU, -3000, GELU_QB, GELU_QC, QLN2, QLN2_INV, FP_BITS, Q1, SHIFT, 1'b1};
    rows[9]  = '{nlop_pkg::OP_EXP,  -5000, EXP_QB,  EXP_QC,  QLN2, QLN2_INV, FP_BITS, Q1, SHIFT, 1'b1};
    rows[10] = '{nlop_pkg::OP_GELU,  1200, GELU_QB, GELU_QC, QLN2, QLN2_INV, FP_BITS, Q1, SHIFT, 1'b1};
    rows[11] = '{nlop_pkg::OP_EXP,  -1500, EXP_QB,  EXP_QC,  QLN2, QLN2_INV, FP_BITS, Q1, SHIFT, 1'b1};
  endtask

  task automatic end_run();
    int total;
    total = errors + mon_errors + uut.u_assertions.fail_reset
            + uut.u_assertions.fail_hold + uut.u_assertions.fail_latency;
    $display("checks %0d, errors %0d, timeouts %0d",
             checks + mon_checks, total, timeouts);
    if (total == 0 && timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic timeout_stop(input string what);
    timeouts++;
    $display("timeout: %s within %0d cycles", what, LIMIT);
    end_run();
  endtask

  task automatic wait_in_ready();
    int n;
    n = 0;
    while (in_ready !== 1'b1) begin
      if (n == LIMIT) timeout_stop("in_ready_o did not go high");
      else begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  task automatic wait_out_valid();
    int n;
    n = 0;
    while (out_valid !== 1'b1) begin
      if (n == LIMIT) timeout_stop("out_valid_o did not go high");
      else begin
        @(negedge clk);
        n++;
      end
    end
  endtask

  // results counted by the monitor on falling edges, so look on rising ones
  task automatic drain();
    int n;
    n = 0;
    while (recv_count != sent_count) begin
      if (n == LIMIT) timeout_stop("not every result came out");
      else begin
        @(posedge clk);
        n++;
      end
    end
    @(negedge clk);
  endtask

  task automatic set_ready_mode(input int m);
    @(posedge clk);
    ready_mode = m;
    @(negedge clk);
  endtask

  task automatic send_row(input int i, input bit check_lat);
    int n;
    int lat;
    wait_in_ready();
    in_valid = 1'b1;
    op       = rows[i].op;
    qin      = rows[i].qin;
    qb       = rows[i].qb;
    qc       = rows[i].qc;
    qln2     = rows[i].qln2;
    qln2_inv = rows[i].qln2_inv;
    fp_bits  = rows[i].fp_bits;
    q1       = rows[i].q1;
    shift    = rows[i].shift;
    exp_vals[sent_count] = model(rows[i]);
    sent_count++;
    @(negedge clk);  // accepted on the edge just passed
    in_valid = 1'b0;
    if (check_lat) begin
      lat = (rows[i].op == nlop_pkg::OP_EXP) ? nlop_pkg::EXP_LATENCY : nlop_pkg::GELU_LATENCY;
      n = 0;
      while (out_valid !== 1'b1) begin
        if (n == LIMIT) timeout_stop("out_valid_o did not rise after accept");
        else begin
          @(negedge clk);
          n++;
        end
      end
      checks++;
      assert (n == lat) else begin
        errors++;
        $display("ERROR %0t out_valid_o latency got %0d expected %0d", $time, n, lat);
      end
    end
  endtask

  // output side: drives out_ready_i, takes results, checks held values
  always @(negedge clk) begin
    if (rst) begin
      held = 1'b0;
    end else begin
      case (ready_mode)
        MODE_RANDOM: begin
          lfsr = lfsr_step(lfsr);
          out_ready = lfsr[0];
        end
        MODE_LOW: out_ready = 1'b0;
        default:  out_ready = 1'b1;
      endcase
      if (held) begin
        mon_checks++;
        assert (qout === held_val) else begin
          mon_errors++;
          $display("ERROR %0t qout_o got %h expected %h (held)", $time, qout, held_val);
        end
      end
      if (out_valid === 1'b1 && out_ready) begin
        mon_checks++;
        if (recv_count >= sent_count) begin
          mon_errors++;
          $display("a result came out with no request outstanding");
        end else begin
          assert (qout === exp_vals[recv_count]) else begin
            mon_errors++;
            $display("ERROR %0t qout_o got %h expected %h", $time, qout, exp_vals[recv_count]);
          end
        end
        recv_count++;
      end
      held = (out_valid === 1'b1) && !out_ready;
      held_val = qout;
    end
  end

  initial begin
    rst      = 1'b1;
    in_valid = 1'b0;
    op       = nlop_pkg::OP_EXP;
    qin      = '0;
    qb       = '0;
    qc       = '0;
    qln2     = '0;
    qln2_inv = '0;
    fp_bits  = '0;
    q1       = '0;
    shift    = '0;
    fill_table();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    checks++;
    assert (in_ready === 1'b1) else begin
      errors++;
      $display("ERROR %0t in_ready_o got %b expected 1", $time, in_ready);
    end
    checks++;
    assert (out_valid === 1'b0) else begin
      errors++;
      $display("ERROR %0t out_valid_o got %b expected 0", $time, out_valid);
    end

    for (int i = 0; i < NROWS; i++) begin
      if (!rows[i].bp) begin
        drain();  // one at a time, so latency is exact
        if (ready_mode != MODE_HIGH) set_ready_mode(MODE_HIGH);
        send_row(i, 1'b1);
      end else begin
        if (ready_mode != MODE_RANDOM) set_ready_mode(MODE_RANDOM);
        send_row(i, 1'b0);
      end
    end
    drain();

    // park one result, then run a second request behind it
    set_ready_mode(MODE_LOW);
    send_row(0, 1'b0);
    wait_out_valid();
    wait_in_ready();
    send_row(4, 1'b0);
    repeat (nlop_pkg::GELU_LATENCY + 2) @(negedge clk);  // second op now stalled
    checks++;
    assert (out_valid === 1'b1) else begin
      errors++;
      $display("ERROR %0t out_valid_o got %b expected 1", $time, out_valid);
    end
    checks++;
    assert (in_ready === 1'b0) else begin
      errors++;
      $display("ERROR %0t in_ready_o got %b expected 0", $time, in_ready);
    end
    set_ready_mode(MODE_HIGH);
    drain();
    end_run();
  end

endmodule

/* tb/nlop_assertions.sv */
`timescale 1ns/1ps

module nlop_assertions (
  input logic            clk,
  input logic            rst,
  input logic            in_valid_i,
  input logic            in_ready_o,
  input logic            out_ready_i,
  input logic            out_valid_o,
  input nlop_pkg::op_t   op_i,
  input nlop_pkg::data_t qout_o
);

  int  ready_run;  // consecutive edges with out_ready_i high
  int  fail_reset = 0;
  int  fail_hold = 0;
  int  fail_latency = 0;
  logic accept_exp;

  assign accept_exp = in_valid_i && in_ready_o && (op_i == nlop_pkg::OP_EXP);

  always_ff @(posedge clk) begin
    if (rst || !out_ready_i) begin
      ready_run <= 0;
    end else if (ready_run < 1000) begin
      ready_run <= ready_run + 1;
    end
  end

  a_idle_after_reset: assert property (@(posedge clk) rst |=> !out_valid_o)
    else begin
      fail_reset++;
      $error("out_valid_o high in the cycle after reset");
    end

  // held result stays put until taken
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(qout_o))
    else begin
      fail_hold++;
      $error("qout_o or out_valid_o changed while the result was held");
    end

  // only judged when out_ready_i was high from accept through the load edge
  a_exp_latency: assert property (@(posedge clk) disable iff (rst)
    accept_exp |-> ##(nlop_pkg::EXP_LATENCY + 1)
      (ready_run <= nlop_pkg::EXP_LATENCY || $rose(out_valid_o)))
    else begin
      fail_latency++;
      $error("out_valid_o did not rise EXP_LATENCY edges after an exp accept");
    end

endmodule

bind nlop_top nlop_assertions u_assertions (
  .clk(clk), .rst(rst),
  .in_valid_i(in_valid_i), .in_ready_o(in_ready_o),
  .out_ready_i(out_ready_i), .out_valid_o(out_valid_o),
  .op_i(op_i), .qout_o(qout_o)
);

/* hdl/nlop_top.sv */
`timescale 1ns/1ps

module nlop_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid_i,
  input  logic              out_ready_i,
  input  nlop_pkg::op_t     op_i,
  input  nlop_pkg::data_t   qin_i,
  input  nlop_pkg::data_t   qb_i,
  input  nlop_pkg::data_t   qc_i,
  input  nlop_pkg::data_t   qln2_i,
  input  nlop_pkg::data_t   qln2_inv_i,
  input  nlop_pkg::data_t   fp_bits_i,
  input  nlop_pkg::data_t   q1_i,
  input  nlop_pkg::data_t   shift_i,
  output logic              in_ready_o,
  output logic              out_valid_o,
  output nlop_pkg::data_t   qout_o
);

  logic start, load, result_free;
  nlop_pkg::op_t op;
  nlop_pkg::wide_t qin, qb, qc, qln2, qln2_inv, fp_bits, q1, shift;
  nlop_pkg::data_t result;

  // unit controls
  logic add_en, add_sub, mul_en, shf_en, sel_en;
  nlop_pkg::src_t add_a, add_b, mul_a, mul_b, shf_src, sel_a, sel_b, res_src;
  nlop_pkg::amt_t shf_amt;
  nlop_pkg::cond_t sel_cond;

  nlop_operand_capture u_capture (
    .clk(clk), .rst(rst),
    .in_valid_i(in_valid_i), .in_ready_i(in_ready_o),
    .op_i(op_i), .qin_i(qin_i), .qb_i(qb_i), .qc_i(qc_i),
    .qln2_i(qln2_i), .qln2_inv_i(qln2_inv_i), .fp_bits_i(fp_bits_i),
    .q1_i(q1_i), .shift_i(shift_i),
    .start_o(start), .op_o(op),
    .qin_o(qin), .qb_o(qb), .qc_o(qc), .qln2_o(qln2), .qln2_inv_o(qln2_inv),
    .fp_bits_o(fp_bits), .q1_o(q1), .shift_o(shift)
  );

  nlop_sequencer u_sequencer (
    .clk(clk), .rst(rst),
    .start_i(start), .result_free_i(result_free), .op_i(op),
    .in_ready_o(in_ready_o), .load_o(load),
    .add_en_o(add_en), .add_sub_o(add_sub), .add_a_o(add_a), .add_b_o(add_b),
    .mul_en_o(mul_en), .mul_a_o(mul_a), .mul_b_o(mul_b),
    .shf_en_o(shf_en), .shf_src_o(shf_src), .shf_amt_o(shf_amt),
    .sel_en_o(sel_en), .sel_cond_o(sel_cond), .sel_a_o(sel_a), .sel_b_o(sel_b),
    .res_src_o(res_src)
  );

  nlop_datapath u_datapath (
    .clk(clk), .rst(rst),
    .add_en_i(add_en), .add_sub_i(add_sub), .add_a_i(add_a), .add_b_i(add_b),
    .mul_en_i(mul_en), .mul_a_i(mul_a), .mul_b_i(mul_b),
    .shf_en_i(shf_en), .shf_src_i(shf_src), .shf_amt_i(shf_amt),
    .sel_en_i(sel_en), .sel_cond_i(sel_cond), .sel_a_i(sel_a), .sel_b_i(sel_b),
    .res_src_i(res_src),
    .qin_i(qin), .qb_i(qb), .qc_i(qc), .qln2_i(qln2), .qln2_inv_i(qln2_inv),
    .fp_bits_i(fp_bits), .q1_i(q1), .shift_i(shift),
    .result_o(result)
  );

  nlop_result_hold u_result (
    .clk(clk), .rst(rst),
    .load_i(load), .out_ready_i(out_ready_i), .result_i(result),
    .result_free_o(result_free), .out_valid_o(out_valid_o), .qout_o(qout_o)
  );

endmodule

/* hdl/nlop_result_hold.sv */
`timescale 1ns/1ps

module nlop_result_hold (
  input  logic              clk,
  input  logic              rst,
  input  logic              load_i,
  input  logic              out_ready_i,
  input  nlop_pkg::data_t   result_i,
  output logic              result_free_o,
  output logic              out_valid_o,
  output nlop_pkg::data_t   qout_o
);

  // empty, or emptied on this edge
  assign result_free_o = !out_valid_o || out_ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_o <= 1'b0;
    end else if (load_i) begin
      out_valid_o <= 1'b1;  // load wins over a transfer out
    end else if (out_ready_i) begin
      out_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load_i) qout_o <= result_i;
  end

endmodule

/* hdl/nlop_datapath.sv */
`timescale 1ns/1ps

module nlop_datapath (
  input  logic              clk,
  input  logic              rst,
  input  logic              add_en_i,
  input  logic              add_sub_i,
  input  nlop_pkg::src_t    add_a_i,
  input  nlop_pkg::src_t    add_b_i,
  input  logic              mul_en_i,
  input  nlop_pkg::src_t    mul_a_i,
  input  nlop_pkg::src_t    mul_b_i,
  input  logic              shf_en_i,
  input  nlop_pkg::src_t    shf_src_i,
  input  nlop_pkg::amt_t    shf_amt_i,
  input  logic              sel_en_i,
  input  nlop_pkg::cond_t   sel_cond_i,
  input  nlop_pkg::src_t    sel_a_i,
  input  nlop_pkg::src_t    sel_b_i,
  input  nlop_pkg::src_t    res_src_i,
  input  nlop_pkg::wide_t   qin_i,
  input  nlop_pkg::wide_t   qb_i,
  input  nlop_pkg::wide_t   qc_i,
  input  nlop_pkg::wide_t   qln2_i,
  input  nlop_pkg::wide_t   qln2_inv_i,
  input  nlop_pkg::wide_t   fp_bits_i,
  input  nlop_pkg::wide_t   q1_i,
  input  nlop_pkg::wide_t   shift_i,
  output nlop_pkg::data_t   result_o
);

  // unit registers
  nlop_pkg::wide_t add_q, mul_q, shf_q, sel_q;

  // muxed operands and unit outputs
  nlop_pkg::wide_t add_a, add_b, add_d;
  nlop_pkg::wide_t mul_a, mul_b, mul_d;
  nlop_pkg::wide_t shf_in, shf_d;
  nlop_pkg::wide_t sel_a, sel_b, sel_d;
  nlop_pkg::wide_t res_w;
  nlop_pkg::shamt_t shamt;
  logic sel_c;

  // resolves a source code, reads captured operands and unit registers
  function automatic nlop_pkg::wide_t pick(input nlop_pkg::src_t src);
    case (src)
      nlop_pkg::SRC_QIN:      pick = qin_i;
      nlop_pkg::SRC_QB:       pick = qb_i;
      nlop_pkg::SRC_QC:       pick = qc_i;
      nlop_pkg::SRC_QLN2:     pick = qln2_i;
      nlop_pkg::SRC_QLN2_INV: pick = qln2_inv_i;
      nlop_pkg::SRC_Q1:       pick = q1_i;
      nlop_pkg::SRC_ADD:      pick = add_q;
      nlop_pkg::SRC_MUL:      pick = mul_q;
      nlop_pkg::SRC_SHF:      pick = shf_q;
      nlop_pkg::SRC_SEL:      pick = sel_q;
      nlop_pkg::SRC_ONE:      pick = nlop_pkg::wide_t'(1);
      nlop_pkg::SRC_NEG_ONE:  pick = '1;  // -1
      nlop_pkg::SRC_TWO:      pick = nlop_pkg::wide_t'(2);
      default:                pick = '0;
    endcase
  endfunction

  always_comb begin
    add_a  = pick(add_a_i);
    add_b  = pick(add_b_i);
    mul_a  = pick(mul_a_i);
    mul_b  = pick(mul_b_i);
    shf_in = pick(shf_src_i);
    sel_a  = pick(sel_a_i);
    sel_b  = pick(sel_b_i);
    res_w  = pick(res_src_i);
  end

  // shift amount from low bits
  always_comb begin
    case (shf_amt_i)
      nlop_pkg::AMT_FP_BITS: shamt = fp_bits_i[nlop_pkg::SHAMT_W-1:0];
      nlop_pkg::AMT_SHIFT:   shamt = shift_i[nlop_pkg::SHAMT_W-1:0];
      nlop_pkg::AMT_SHF:     shamt = shf_q[nlop_pkg::SHAMT_W-1:0];
      default:               shamt = '0;
    endcase
  end

  always_comb begin
    case (sel_cond_i)
      nlop_pkg::COND_QIN_NEG: sel_c = qin_i[nlop_pkg::WIDE_W-1];
      nlop_pkg::COND_ADD_NEG: sel_c = add_q[nlop_pkg::WIDE_W-1];
      default:                sel_c = 1'b0;
    endcase
  end

  assign add_d = add_sub_i ? add_a - add_b : add_a + add_b;  // wraps at 64 bits
  assign mul_d = mul_a * mul_b;                              // low 64 bits kept
  assign shf_d = shf_in >>> shamt;                           // arithmetic
  assign sel_d = sel_c ? sel_b : sel_a;

  always_ff @(posedge clk) begin
    if (rst) begin
      add_q <= '0;
      mul_q <= '0;
      shf_q <= '0;
      sel_q <= '0;
    end else begin
      if (add_en_i) add_q <= add_d;
      if (mul_en_i) mul_q <= mul_d;
      if (shf_en_i) shf_q <= shf_d;
      if (sel_en_i) sel_q <= sel_d;
    end
  end

  assign result_o = res_w[nlop_pkg::DATA_W-1:0];

endmodule

/* hdl/nlop_sequencer.sv */
`timescale 1ns/1ps

module nlop_sequencer (
  input  logic              clk,
  input  logic              rst,
  input  logic              start_i,
  input  logic              result_free_i,
  input  nlop_pkg::op_t     op_i,
  output logic              in_ready_o,
  output logic              load_o,
  output logic              add_en_o,
  output logic              add_sub_o,
  output nlop_pkg::src_t    add_a_o,
  output nlop_pkg::src_t    add_b_o,
  output logic              mul_en_o,
  output nlop_pkg::src_t    mul_a_o,
  output nlop_pkg::src_t    mul_b_o,
  output logic              shf_en_o,
  output nlop_pkg::src_t    shf_src_o,
  output nlop_pkg::amt_t    shf_amt_o,
  output logic              sel_en_o,
  output nlop_pkg::cond_t   sel_cond_o,
  output nlop_pkg::src_t    sel_a_o,
  output nlop_pkg::src_t    sel_b_o,
  output nlop_pkg::src_t    res_src_o
);

  nlop_pkg::step_t state_q, state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      nlop_pkg::ST_IDLE:    if (start_i) state_d = nlop_pkg::ST_S1;
      nlop_pkg::ST_S8:      state_d = (op_i == nlop_pkg::OP_EXP) ? nlop_pkg::ST_DELIVER
                                                                 : nlop_pkg::ST_S9;
      nlop_pkg::ST_S11:     state_d = nlop_pkg::ST_DELIVER;
      nlop_pkg::ST_DELIVER: if (result_free_i) state_d = nlop_pkg::ST_IDLE;
      default:              state_d = nlop_pkg::step_t'(state_q + 4'd1);
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) state_q <= nlop_pkg::ST_IDLE;
    else     state_q <= state_d;
  end

  assign in_ready_o = (state_q == nlop_pkg::ST_IDLE);
  assign load_o     = (state_q == nlop_pkg::ST_DELIVER) && result_free_i;  // hand off result
  assign res_src_o  = (op_i == nlop_pkg::OP_GELU) ? nlop_pkg::SRC_MUL : nlop_pkg::SRC_SHF;

  // per-step unit controls
  always_comb begin
    add_en_o   = 1'b0;
    add_sub_o  = 1'b0;
    add_a_o    = nlop_pkg::SRC_ZERO;
    add_b_o    = nlop_pkg::SRC_ZERO;
    mul_en_o   = 1'b0;
    mul_a_o    = nlop_pkg::SRC_ZERO;
    mul_b_o    = nlop_pkg::SRC_ZERO;
    shf_en_o   = 1'b0;
    shf_src_o  = nlop_pkg::SRC_ZERO;
    shf_amt_o  = nlop_pkg::AMT_FP_BITS;
    sel_en_o   = 1'b0;
    sel_cond_o = nlop_pkg::COND_ZERO;
    sel_a_o    = nlop_pkg::SRC_ZERO;
    sel_b_o    = nlop_pkg::SRC_ZERO;
    if (op_i == nlop_pkg::OP_EXP) begin
      case (state_q)
        nlop_pkg::ST_S1: begin  // qin * qln2_inv
          mul_en_o = 1'b1;
          mul_a_o  = nlop_pkg::SRC_QIN;
          mul_b_o  = nlop_pkg::SRC_QLN2_INV;
        end
        nlop_pkg::ST_S2: begin  // z
          shf_en_o  = 1'b1;
          shf_src_o = nlop_pkg::SRC_MUL;
          shf_amt_o = nlop_pkg::AMT_FP_BITS;
        end
        nlop_pkg::ST_S3: begin
          mul_en_o = 1'b1;
          mul_a_o  = nlop_pkg::SRC_QLN2;
          mul_b_o  = nlop_pkg::SRC_SHF;
        end
        nlop_pkg::ST_S4: begin  // p = qin - z*qln2
          add_en_o  = 1'b1;
          add_sub_o = 1'b1;
          add_a_o   = nlop_pkg::SRC_QIN;
          add_b_o   = nlop_pkg::SRC_MUL;
        end
        nlop_pkg::ST_S5: begin  // keep p in sel while adder forms p + qb
          add_en_o = 1'b1;
          add_a_o  = nlop_pkg::SRC_ADD;
          add_b_o  = nlop_pkg::SRC_QB;
          sel_en_o = 1'b1;
          sel_a_o  = nlop_pkg::SRC_ADD;
        end
        nlop_pkg::ST_S6: begin
          mul_en_o = 1'b1;
          mul_a_o  = nlop_pkg::SRC_ADD;
          mul_b_o  = nlop_pkg::SRC_SEL;
        end
        nlop_pkg::ST_S7: begin
          add_en_o = 1'b1;
          add_a_o  = nlop_pkg::SRC_MUL;
          add_b_o  = nlop_pkg::SRC_QC;
        end
        nlop_pkg::ST_S8: begin  // poly >> z
          shf_en_o  = 1'b1;
          shf_src_o = nlop_pkg::SRC_ADD;
          shf_amt_o = nlop_pkg::AMT_SHF;
        end
        default: ;
      endcase
    end else begin
      case (state_q)
        nlop_pkg::ST_S1: begin  // -qin
          mul_en_o = 1'b1;
          mul_a_o  = nlop_pkg::SRC_QIN;
          mul_b_o  = nlop_pkg::SRC_NEG_ONE;
        end
        nlop_pkg::ST_S2: begin  // |qin| and -qb
          sel_en_o   = 1'b1;
          sel_cond_o = nlop_pkg::COND_QIN_NEG;
          sel_a_o    = nlop_pkg::SRC_QIN;
          sel_b_o    = nlop_pkg::SRC_MUL;
          mul_en_o   = 1'b1;
          mul_a_o    = nlop_pkg::SRC_QB;
          mul_b_o    = nlop_pkg::SRC_NEG_ONE;
        end
        nlop_pkg::ST_S3, nlop_pkg::ST_S5: begin  // -qb - |qin|, then 2qb + clip
          add_en_o  = 1'b1;
          add_sub_o = (state_q == nlop_pkg::ST_S3);
          add_a_o   = nlop_pkg::SRC_MUL;
          add_b_o   = nlop_pkg::SRC_SEL;
        end
        nlop_pkg::ST_S4: begin  // clip, 2*qb
          sel_en_o   = 1'b1;
          sel_cond_o = nlop_pkg::COND_ADD_NEG;
          sel_a_o    = nlop_pkg::SRC_SEL;
          sel_b_o    = nlop_pkg::SRC_MUL;
          mul_en_o   = 1'b1;
          mul_a_o    = nlop_pkg::SRC_QB;
          mul_b_o    = nlop_pkg::SRC_TWO;
        end
        nlop_pkg::ST_S6, nlop_pkg::ST_S8: begin
          mul_en_o = 1'b1;
          mul_a_o  = nlop_pkg::SRC_ADD;
          mul_b_o  = nlop_pkg::SRC_SEL;
        end
        nlop_pkg::ST_S7: begin  // + qc, and sign of qin
          add_en_o   = 1'b1;
          add_a_o    = nlop_pkg::SRC_MUL;
          add_b_o    = nlop_pkg::SRC_QC;
          sel_en_o   = 1'b1;
          sel_cond_o = nlop_pkg::COND_QIN_NEG;
          sel_a_o    = nlop_pkg::SRC_ONE;
          sel_b_o    = nlop_pkg::SRC_NEG_ONE;
        end
        nlop_pkg::ST_S9: begin
          shf_en_o  = 1'b1;
          shf_src_o = nlop_pkg::SRC_MUL;
          shf_amt_o = nlop_pkg::AMT_SHIFT;
        end
        nlop_pkg::ST_S10: begin
          add_en_o = 1'b1;
          add_a_o  = nlop_pkg::SRC_SHF;
          add_b_o  = nlop_pkg::SRC_Q1;
        end
        nlop_pkg::ST_S11: begin  // qin * (L + q1)
          mul_en_o = 1'b1;
          mul_a_o  = nlop_pkg::SRC_ADD;
          mul_b_o  = nlop_pkg::SRC_QIN;
        end
        default: ;
      endcase
    end
  end

endmodule

/* hdl/nlop_operand_capture.sv */
`timescale 1ns/1ps

module nlop_operand_capture (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid_i,
  input  logic              in_ready_i,
  input  nlop_pkg::op_t     op_i,
  input  nlop_pkg::data_t   qin_i,
  input  nlop_pkg::data_t   qb_i,
  input  nlop_pkg::data_t   qc_i,
  input  nlop_pkg::data_t   qln2_i,
  input  nlop_pkg::data_t   qln2_inv_i,
  input  nlop_pkg::data_t   fp_bits_i,
  input  nlop_pkg::data_t   q1_i,
  input  nlop_pkg::data_t   shift_i,
  output logic              start_o,
  output nlop_pkg::op_t     op_o,
  output nlop_pkg::wide_t   qin_o,
  output nlop_pkg::wide_t   qb_o,
  output nlop_pkg::wide_t   qc_o,
  output nlop_pkg::wide_t   qln2_o,
  output nlop_pkg::wide_t   qln2_inv_o,
  output nlop_pkg::wide_t   fp_bits_o,
  output nlop_pkg::wide_t   q1_o,
  output nlop_pkg::wide_t   shift_o
);

  function automatic nlop_pkg::wide_t sext(input nlop_pkg::data_t v);
    sext = {{nlop_pkg::DATA_W{v[nlop_pkg::DATA_W-1]}}, v};
  endfunction

  assign start_o = in_valid_i && in_ready_i;  // accept

  always_ff @(posedge clk) begin
    if (rst) begin
      op_o <= nlop_pkg::OP_EXP;
    end else if (start_o) begin
      op_o <= op_i;
    end
  end

  // coefficients held until the next accept
  always_ff @(posedge clk) begin
    if (start_o) begin
      qin_o      <= sext(qin_i);
      qb_o       <= sext(qb_i);
      qc_o       <= sext(qc_i);
      qln2_o     <= sext(qln2_i);
      qln2_inv_o <= sext(qln2_inv_i);
      fp_bits_o  <= sext(fp_bits_i);
      q1_o       <= sext(q1_i);
      shift_o    <= sext(shift_i);
    end
  end

endmodule

/* hdl/nlop_pkg.sv */
package nlop_pkg;

  localparam int DATA_W = 32;          // external word
  localparam int WIDE_W = 2 * DATA_W;  // internal word
  localparam int SHAMT_W = $clog2(WIDE_W);

  // clock edges from accept to out_valid, output side free
  localparam int EXP_LATENCY = 9;
  localparam int GELU_LATENCY = 12;

  typedef logic [DATA_W-1:0] data_t;
  typedef logic signed [WIDE_W-1:0] wide_t;
  typedef logic [SHAMT_W-1:0] shamt_t;  // low bits of a wide value

  typedef enum logic {
    OP_EXP  = 1'b0,
    OP_GELU = 1'b1
  } op_t;

  typedef enum logic [3:0] {
    ST_IDLE    = 4'd0,
    ST_S1      = 4'd1,
    ST_S2      = 4'd2,
    ST_S3      = 4'd3,
    ST_S4      = 4'd4,
    ST_S5      = 4'd5,
    ST_S6      = 4'd6,
    ST_S7      = 4'd7,
    ST_S8      = 4'd8,
    ST_S9      = 4'd9,
    ST_S10     = 4'd10,
    ST_S11     = 4'd11,
    ST_DELIVER = 4'd12
  } step_t;

  typedef enum logic [3:0] {
    SRC_QIN, SRC_QB, SRC_QC, SRC_QLN2, SRC_QLN2_INV, SRC_Q1,
    SRC_ADD, SRC_MUL, SRC_SHF, SRC_SEL,
    SRC_ONE, SRC_NEG_ONE, SRC_TWO, SRC_ZERO
  } src_t;

  typedef enum logic [1:0] {
    AMT_FP_BITS, AMT_SHIFT, AMT_SHF
  } amt_t;

  typedef enum logic [1:0] {
    COND_ZERO, COND_QIN_NEG, COND_ADD_NEG
  } cond_t;

endpackage
